// ==== Bender.yml ====
package:
  name: pipe_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/ctrl_pkg.sv
      - common/fwd_if.sv
      - hw/ctrl_fsm/ctrl_fsm.sv
      - hw/operand_fwd.sv
      - hw/stall_unit.sv
      - hw/pipe_ctrl_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/pipe_ctrl_props.sv
      - verif/tb_pipe_ctrl.sv

// ==== build.f ====
+incdir+common
common/ctrl_pkg.sv
common/fwd_if.sv
hw/ctrl_fsm/ctrl_fsm.sv
hw/operand_fwd.sv
hw/stall_unit.sv
hw/pipe_ctrl_top.sv
verif/pipe_ctrl_props.sv
verif/tb_pipe_ctrl.sv

// ==== common/ctrl_config.svh ====
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// source operands per instruction (a, b, c)
`define CTRL_NUM_OPERANDS 3

// operand a carries the jalr target register
`define CTRL_OPERAND_A 0

// field widths shared by package and interface
`define CTRL_PC_MUX_W 3
`define CTRL_FW_SEL_W 2
`define CTRL_JUMP_W 2

`endif

// ==== common/ctrl_pkg.sv ====
`include "ctrl_config.svh"

package ctrl_pkg;

  // pc source requested from the fetch stage
  typedef enum logic [`CTRL_PC_MUX_W-1:0] {
    PC_BOOT   = 3'b000,
    PC_JUMP   = 3'b010,
    PC_BRANCH = 3'b011
  } pc_mux_e;

  // operand source in the id stage
  typedef enum logic [`CTRL_FW_SEL_W-1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // jump kind reported by the decoder
  typedef enum logic [`CTRL_JUMP_W-1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_e;

  // sequencing fsm states
  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH_EX,
    FLUSH_WB
  } ctrl_state_e;

endpackage

// ==== common/fwd_if.sv ====
`include "ctrl_config.svh"

// per-operand forwarding results, one slot per source operand
interface fwd_if;

  // forwarding mux select per operand
  logic [`CTRL_FW_SEL_W-1:0] fw_sel [`CTRL_NUM_OPERANDS];
  // load in ex writes this operand
  logic [`CTRL_NUM_OPERANDS-1:0] load_hit;
  // some stage still has a write in flight to this operand
  logic [`CTRL_NUM_OPERANDS-1:0] wr_pending;

  // each forwarding unit drives only its own index
  modport unit (output fw_sel, output load_hit, output wr_pending);

  // stall logic and top level only observe
  modport sink (input fw_sel, input load_hit, input wr_pending);

endinterface

// ==== hw/ctrl_fsm/ctrl_fsm.sv ====
module ctrl_fsm
  import ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  // core start / wake request
  input  logic     fetch_enable_i,
  // id stage status
  input  logic     instr_valid_i,
  input  logic     id_ready_i,
  // ex stage status
  input  logic     branch_taken_ex_i,
  input  logic     ex_valid_i,
  // decoder hints
  input  jump_e    jump_in_dec_i,
  input  logic     pipe_flush_i,
  // jalr operand not yet available
  input  logic     jr_stall_i,

  output logic     instr_req_o,
  output logic     ctrl_busy_o,
  output logic     is_decoding_o,
  output logic     pc_set_o,
  output pc_mux_e  pc_mux_o,
  output logic     halt_if_o,
  output logic     halt_id_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // a jump already redirected fetch for the instruction held in id
  logic jump_done;
  logic jump_done_q;

  ////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    // defaults, core running and fetching
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    pc_set_o      = 1'b0;
    pc_mux_o      = PC_BOOT;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    jump_done     = jump_done_q;
    state_d       = state_q;

    unique case (state_q)
      // idle after reset until fetch is enabled
      RESET:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // single cycle load of the boot address
      BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_mux_o = PC_BOOT;
        state_d  = FIRST_FETCH;
      end

      // pipeline drained, wait for fetch enable
      SLEEP:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_enable_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach id
      FIRST_FETCH:
      begin
        if (id_ready_i)
          state_d = DECODE;
      end

      DECODE:
      begin
        // nothing to decode while a taken branch is squashing id
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          // jal/jalr target known in id, redirect once per instruction
          if ((jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR))
          begin
            pc_mux_o = PC_JUMP;
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o  = 1'b1;
              jump_done = 1'b1;
            end
          end

          // wfi or fence style flush, stop if and id right away
          if (pipe_flush_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // taken branch in ex wins over anything decoded this cycle
        if (branch_taken_ex_i)
        begin
          pc_mux_o      = PC_BRANCH;
          pc_set_o      = 1'b1;
          is_decoding_o = 1'b0;
        end
      end

      // nop into ex, wait for ex to finish
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // nop into wb, then resume or go to sleep
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i)
        begin
          // fetch may restart in the same cycle
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end
        else
        begin
          state_d = SLEEP;
        end
      end

      // unused encoding, recover through reset state
      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // id accepting a new instruction clears the flag
      jump_done_q <= jump_done & ~id_ready_i;
    end
  end

endmodule

// ==== hw/operand_fwd.sv ====
module operand_fwd
  import ctrl_pkg::*;
#(
  parameter int OPERAND_IDX = 0
)
(
  // write enables of the three writing ports
  input  logic regfile_we_ex_i,
  input  logic regfile_we_wb_i,
  input  logic regfile_alu_we_fw_i,
  // ex stage holds a memory access
  input  logic data_req_ex_i,
  // destination of each stage matches this operand
  input  logic reg_d_ex_is_reg_i,
  input  logic reg_d_wb_is_reg_i,
  input  logic reg_d_alu_is_reg_i,

  fwd_if.unit  fwd
);

  fw_sel_e sel;

  // alu port over wb over register file
  always_comb
  begin
    sel = SEL_REGFILE;
    if (regfile_we_wb_i && reg_d_wb_is_reg_i)
      sel = SEL_FW_WB;
    // newest value sits on the alu port
    if (regfile_alu_we_fw_i && reg_d_alu_is_reg_i)
      sel = SEL_FW_EX;
  end

  assign fwd.fw_sel[OPERAND_IDX] = sel;

  // load data arrives too late to forward, id must wait
  assign fwd.load_hit[OPERAND_IDX] = data_req_ex_i & regfile_we_ex_i & reg_d_ex_is_reg_i;

  // any writer still targeting this operand
  assign fwd.wr_pending[OPERAND_IDX] = (regfile_we_wb_i & reg_d_wb_is_reg_i)
                                     | (regfile_we_ex_i & reg_d_ex_is_reg_i)
                                     | (regfile_alu_we_fw_i & reg_d_alu_is_reg_i);

endmodule

// ==== hw/pipe_ctrl_top.sv ====
`include "ctrl_config.svh"

module pipe_ctrl_top
  import ctrl_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,

  // fsm inputs
  input  logic    fetch_enable_i,
  input  logic    instr_valid_i,
  input  logic    branch_taken_ex_i,
  input  jump_e   jump_in_dec_i,
  input  logic    pipe_flush_i,
  input  logic    id_ready_i,
  input  logic    ex_valid_i,
  input  logic    illegal_insn_i,

  // forwarding inputs
  input  logic    regfile_we_ex_i,
  input  logic    regfile_we_wb_i,
  input  logic    regfile_alu_we_fw_i,
  input  logic    data_req_ex_i,
  input  logic    data_misaligned_i,
  input  logic    reg_d_ex_is_reg_a_i,
  input  logic    reg_d_ex_is_reg_b_i,
  input  logic    reg_d_ex_is_reg_c_i,
  input  logic    reg_d_wb_is_reg_a_i,
  input  logic    reg_d_wb_is_reg_b_i,
  input  logic    reg_d_wb_is_reg_c_i,
  input  logic    reg_d_alu_is_reg_a_i,
  input  logic    reg_d_alu_is_reg_b_i,
  input  logic    reg_d_alu_is_reg_c_i,

  // fetch and pipeline control
  output logic    instr_req_o,
  output logic    ctrl_busy_o,
  output logic    is_decoding_o,
  output logic    pc_set_o,
  output pc_mux_e pc_mux_o,
  output logic    halt_if_o,
  output logic    halt_id_o,

  // forwarding and stalls
  output fw_sel_e operand_a_fw_mux_sel_o,
  output fw_sel_e operand_b_fw_mux_sel_o,
  output fw_sel_e operand_c_fw_mux_sel_o,
  output logic    load_stall_o,
  output logic    jr_stall_o,
  output logic    deassert_we_o,
  output logic    misaligned_stall_o
);

  // match bits gathered per stage, index 0 is operand a
  logic [`CTRL_NUM_OPERANDS-1:0] d_ex_is;
  logic [`CTRL_NUM_OPERANDS-1:0] d_wb_is;
  logic [`CTRL_NUM_OPERANDS-1:0] d_alu_is;

  assign d_ex_is  = {reg_d_ex_is_reg_c_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_a_i};
  assign d_wb_is  = {reg_d_wb_is_reg_c_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_a_i};
  assign d_alu_is = {reg_d_alu_is_reg_c_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_a_i};

  fwd_if fwd ();

  ////////////////////////////////////////////////////////////
  // sequencing fsm
  ////////////////////////////////////////////////////////////
  ctrl_fsm u_ctrl_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .id_ready_i        (id_ready_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .ex_valid_i        (ex_valid_i),
    .jump_in_dec_i     (jump_in_dec_i),
    .pipe_flush_i      (pipe_flush_i),
    .jr_stall_i        (jr_stall_o),
    .instr_req_o       (instr_req_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o)
  );

  ////////////////////////////////////////////////////////////
  // forwarding, one unit per source operand
  ////////////////////////////////////////////////////////////
  for (genvar i = 0; i < `CTRL_NUM_OPERANDS; i++)
  begin : g_operand
    operand_fwd #(
      .OPERAND_IDX (i)
    ) u_operand_fwd (
      .regfile_we_ex_i     (regfile_we_ex_i),
      .regfile_we_wb_i     (regfile_we_wb_i),
      .regfile_alu_we_fw_i (regfile_alu_we_fw_i),
      .data_req_ex_i       (data_req_ex_i),
      .reg_d_ex_is_reg_i   (d_ex_is[i]),
      .reg_d_wb_is_reg_i   (d_wb_is[i]),
      .reg_d_alu_is_reg_i  (d_alu_is[i]),
      .fwd                 (fwd.unit)
    );
  end

  ////////////////////////////////////////////////////////////
  // stalls
  ////////////////////////////////////////////////////////////
  stall_unit u_stall_unit (
    .jump_in_dec_i  (jump_in_dec_i),
    .illegal_insn_i (illegal_insn_i),
    .is_decoding_i  (is_decoding_o),
    .fwd            (fwd.sink),
    .load_stall_o   (load_stall_o),
    .jr_stall_o     (jr_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

  // selects back out to the id stage muxes
  assign operand_a_fw_mux_sel_o = fw_sel_e'(fwd.fw_sel[0]);
  assign operand_b_fw_mux_sel_o = fw_sel_e'(fwd.fw_sel[1]);
  assign operand_c_fw_mux_sel_o = fw_sel_e'(fwd.fw_sel[2]);

  // misaligned access stall comes straight from the lsu
  assign misaligned_stall_o = data_misaligned_i;

endmodule

// ==== hw/stall_unit.sv ====
`include "ctrl_config.svh"

module stall_unit
  import ctrl_pkg::*;
(
  input  jump_e jump_in_dec_i,
  input  logic  illegal_insn_i,
  // fsm is decoding the instruction in id
  input  logic  is_decoding_i,

  fwd_if.sink   fwd,

  output logic  load_stall_o,
  output logic  jr_stall_o,
  output logic  deassert_we_o
);

  ////////////////////////////////////////////////////////////
  // hazard stalls
  ////////////////////////////////////////////////////////////

  // load-use on any source operand
  assign load_stall_o = |fwd.load_hit;

  // jalr target register still being written somewhere downstream
  // independent of fsm state so no loop through is_decoding
  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) && fwd.wr_pending[`CTRL_OPERAND_A];

  ////////////////////////////////////////////////////////////
  // write enable kill
  ////////////////////////////////////////////////////////////

  // instruction in id must not write back when
  //   not decoding, illegal, or held by a stall
  assign deassert_we_o = !is_decoding_i
                       || illegal_insn_i
                       || load_stall_o
                       || jr_stall_o;

endmodule

// ==== verif/pipe_ctrl_props.sv ====
module pipe_ctrl_props
  import ctrl_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input logic    branch_taken_ex_i,
  input logic    pc_set_o,
  input pc_mux_e pc_mux_o,
  input logic    load_stall_o,
  input logic    deassert_we_o
);

  // number of failed assertions
  int unsigned fail_count = 0;

  // a load-use stall always kills the write enable
  a_load_kills_we: assert property (
    @(posedge clk) disable iff (!rst_n)
    load_stall_o |-> deassert_we_o
  )
  else
  begin
    $error("load stall without write enable deassert");
    fail_count++;
  end

  // boot address is set for one cycle and first fetch follows
  a_boot_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pc_set_o && (pc_mux_o == PC_BOOT)) |=> !pc_set_o
  )
  else
  begin
    $error("boot pc set held longer than one cycle");
    fail_count++;
  end

  // ex never reports two taken branches in a row
  a_branch_spacing: assert property (
    @(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i
  )
  else
  begin
    $error("taken branches back to back");
    fail_count++;
  end

endmodule

// ==== verif/tb_pipe_ctrl.sv ====
`include "ctrl_config.svh"

module tb_pipe_ctrl
  import ctrl_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  localparam int NUM_CYCLES = 2000;
  localparam int TIMEOUT    = 2 * NUM_CYCLES * CLK_PERIOD;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    fetch_enable_i, instr_valid_i, branch_taken_ex_i, pipe_flush_i;
  logic    id_ready_i, ex_valid_i, illegal_insn_i;
  jump_e   jump_in_dec_i;
  logic    regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic    data_req_ex_i, data_misaligned_i;
  logic    reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i;
  logic    reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i;
  logic    reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i;
  logic    instr_req_o, ctrl_busy_o, is_decoding_o, pc_set_o, halt_if_o, halt_id_o;
  pc_mux_e pc_mux_o;
  fw_sel_e operand_a_fw_mux_sel_o, operand_b_fw_mux_sel_o, operand_c_fw_mux_sel_o;
  logic    load_stall_o, jr_stall_o, deassert_we_o, misaligned_stall_o;

  // random source state and branch spacing
  logic [31:0] lfsr = 32'h91a0;
  logic        last_branch = 1'b0;

  // reference model state
  ctrl_state_e m_state = RESET;
  ctrl_state_e m_next;
  logic        m_jd = 1'b0;
  logic        m_jd_next;
  // expected outputs
  logic    e_req, e_busy, e_dec, e_pcset, e_hif, e_hid, e_fire;
  pc_mux_e e_mux;
  fw_sel_e e_sel [`CTRL_NUM_OPERANDS];
  logic [`CTRL_NUM_OPERANDS-1:0] e_hit, e_pend, ex_m, wb_m, alu_m;
  logic    e_load, e_jr, e_dwe, jump_kind;

  pipe_ctrl_top UUT (.*);

  bind pipe_ctrl_top pipe_ctrl_props u_props (
    .clk               (clk),
    .rst_n             (rst_n),
    .branch_taken_ex_i (branch_taken_ex_i),
    .pc_set_o          (pc_set_o),
    .pc_mux_o          (pc_mux_o),
    .load_stall_o      (load_stall_o),
    .deassert_we_o     (deassert_we_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // random bits
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [7:0] take_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[6:0], next_bit()};
    return v;
  endfunction

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
    begin
      $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  task automatic apply_stimulus();
    logic       br;
    logic [7:0] bits;
    // fetch enable drops about one cycle in eight
    fetch_enable_i      <= (take_bits(3) != 3'b000);
    instr_valid_i       <= (take_bits(2) != 2'b00);
    id_ready_i          <= (take_bits(2) != 2'b00);
    ex_valid_i          <= next_bit();
    pipe_flush_i        <= (take_bits(3) == 3'b000);
    illegal_insn_i      <= (take_bits(3) == 3'b000);
    bits = take_bits(2);
    jump_in_dec_i       <= jump_e'(bits[1:0]);
    // taken branches never back to back
    br = (take_bits(2) == 2'b00) && !last_branch;
    last_branch = br;
    branch_taken_ex_i   <= br;
    regfile_we_ex_i     <= next_bit();
    regfile_we_wb_i     <= next_bit();
    regfile_alu_we_fw_i <= next_bit();
    data_req_ex_i       <= next_bit();
    data_misaligned_i   <= next_bit();
    bits = take_bits(3);
    {reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i}    <= bits[2:0];
    bits = take_bits(3);
    {reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i}    <= bits[2:0];
    bits = take_bits(3);
    {reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i} <= bits[2:0];
  endtask

  initial
  begin
    rst_n <= 1'b0;
    {fetch_enable_i, instr_valid_i, branch_taken_ex_i, pipe_flush_i} <= '0;
    {id_ready_i, ex_valid_i, illegal_insn_i, data_misaligned_i} <= '0;
    {regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i, data_req_ex_i} <= '0;
    {reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i} <= '0;
    {reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i} <= '0;
    {reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i} <= '0;
    jump_in_dec_i <= BRANCH_NONE;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int c = 0; c < NUM_CYCLES; c++)
    begin
      @(posedge clk);
      apply_stimulus();
    end
    // let the last negedge checks and edge assertions run
    repeat (2) @(posedge clk);
    #1;
    $display("Done: no errors");
    $finish;
  end

  always @(UUT.u_props.fail_count)
  begin
    if (UUT.u_props.fail_count != 0)
    begin
      $display("Done: errors found");
      $fatal(1);
    end
  end

  initial
  begin
    #(TIMEOUT);
    $display("watchdog expired before the stimulus finished");
    $display("Done: errors found");
    $fatal(1);
  end

  ////////////////////////////////////////////////////////////
  // reference model evaluated mid cycle while inputs are stable
  ////////////////////////////////////////////////////////////
  always @(negedge clk)
  begin
    ex_m  = {reg_d_ex_is_reg_c_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_a_i};
    wb_m  = {reg_d_wb_is_reg_c_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_a_i};
    alu_m = {reg_d_alu_is_reg_c_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_a_i};
    // forwarding where the newest writer wins
    for (int k = 0; k < `CTRL_NUM_OPERANDS; k++)
    begin
      if (regfile_alu_we_fw_i && alu_m[k])
        e_sel[k] = SEL_FW_EX;
      else if (regfile_we_wb_i && wb_m[k])
        e_sel[k] = SEL_FW_WB;
      else
        e_sel[k] = SEL_REGFILE;
      e_hit[k]  = data_req_ex_i && regfile_we_ex_i && ex_m[k];
      e_pend[k] = (regfile_we_ex_i && ex_m[k]) || (regfile_we_wb_i && wb_m[k])
                  || (regfile_alu_we_fw_i && alu_m[k]);
    end
    e_load = |e_hit;
    e_jr   = (jump_in_dec_i == BRANCH_JALR) && e_pend[`CTRL_OPERAND_A];

    // fsm rules
    {e_dec, e_pcset, e_hif, e_hid, e_fire} = '0;
    e_req     = !(m_state inside {RESET, SLEEP});
    e_busy    = e_req;
    e_mux     = PC_BOOT;
    m_next    = m_state;
    m_jd_next = m_jd;
    jump_kind = jump_in_dec_i inside {BRANCH_JAL, BRANCH_JALR};
    case (m_state)
      RESET:       m_next = fetch_enable_i ? BOOT_SET : RESET;
      BOOT_SET:
      begin
        e_pcset = 1'b1;
        m_next  = FIRST_FETCH;
      end
      SLEEP:
      begin
        {e_hif, e_hid} = 2'b11;
        m_next = fetch_enable_i ? FIRST_FETCH : SLEEP;
      end
      FIRST_FETCH: m_next = id_ready_i ? DECODE : FIRST_FETCH;
      DECODE:
      begin
        e_dec  = instr_valid_i && !branch_taken_ex_i;
        e_fire = e_dec && jump_kind && !e_jr && !m_jd;
        if (e_dec && jump_kind)
          e_mux = PC_JUMP;
        if (branch_taken_ex_i)
          e_mux = PC_BRANCH;
        e_pcset = e_fire || branch_taken_ex_i;
        m_jd_next = m_jd || e_fire;
        if (e_dec && pipe_flush_i)
        begin
          {e_hif, e_hid} = 2'b11;
          m_next = FLUSH_EX;
        end
      end
      FLUSH_EX:
      begin
        {e_hif, e_hid} = 2'b11;
        m_next = ex_valid_i ? FLUSH_WB : FLUSH_EX;
      end
      FLUSH_WB:
      begin
        e_hif  = !fetch_enable_i;
        e_hid  = 1'b1;
        m_next = fetch_enable_i ? DECODE : SLEEP;
      end
      default:     m_next = RESET;
    endcase
    e_dwe = !e_dec || illegal_insn_i || e_load || e_jr;

    check_value("instr_req_o", instr_req_o, e_req);
    check_value("ctrl_busy_o", ctrl_busy_o, e_busy);
    check_value("is_decoding_o", is_decoding_o, e_dec);
    check_value("pc_set_o", pc_set_o, e_pcset);
    check_value("pc_mux_o", pc_mux_o, e_mux);
    check_value("halt_if_o", halt_if_o, e_hif);
    check_value("halt_id_o", halt_id_o, e_hid);
    check_value("operand_a_fw_mux_sel_o", operand_a_fw_mux_sel_o, e_sel[0]);
    check_value("operand_b_fw_mux_sel_o", operand_b_fw_mux_sel_o, e_sel[1]);
    check_value("operand_c_fw_mux_sel_o", operand_c_fw_mux_sel_o, e_sel[2]);
    check_value("load_stall_o", load_stall_o, e_load);
    check_value("jr_stall_o", jr_stall_o, e_jr);
    check_value("deassert_we_o", deassert_we_o, e_dwe);
    check_value("misaligned_stall_o", misaligned_stall_o, data_misaligned_i);

    // commit what the next rising edge will register
    if (!rst_n)
    begin
      m_state = RESET;
      m_jd    = 1'b0;
    end
    else
    begin
      m_state = m_next;
      m_jd    = m_jd_next && !id_ready_i;
    end
  end

endmodule
